// File: tb.f
+incdir+common
common/exu_dec_pkg.sv
common/exu_res_pkg.sv
common/exu_req_ifs.sv
exu/exu_dispatch.sv
exu/exu_alu.sv
exu/exu_bjp.sv
exu/exu_commit.sv
exu/exu_top.sv
verif/tb_exu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the EXU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir -o tb_exu_top \
    --top-module tb_exu_top -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exu_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: verif/tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module tb_exu_top import exu_dec_pkg::*; import exu_res_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 4;
    localparam int ALU_REPS   = 2;   // Per op and operand source
    localparam int BR_REPS    = 6;   // Per branch kind
    localparam int JMP_REPS   = 4;   // Per JAL and JALR
    localparam int MISC_REPS  = 3;
    localparam int N_TXN      = 24 * ALU_REPS + 6 * BR_REPS + 2 * JMP_REPS + 4 * MISC_REPS;
    localparam int WD_NS      = (N_TXN * 10 + RST_CYCLES) * CLK_PERIOD;

    logic      clk;
    logic      rst_n_i;
    logic      req_i;
    dec_info_t dec_info_i;
    xlen_t     dec_imm_i;
    xlen_t     dec_pc_i;
    xlen_t     rs1_rdata_i;
    xlen_t     rs2_rdata_i;
    reg_addr_t rd_addr_i;
    logic      ack_o;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    res_data_t wb_data_o;
    logic      jump_o;
    pc_t       jump_addr_o;

    logic [31:0] lfsr_q = 32'd87735;

    exu_top dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .dec_info_i  (dec_info_i),
        .dec_imm_i   (dec_imm_i),
        .dec_pc_i    (dec_pc_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .rd_addr_i   (rd_addr_i),
        .ack_o       (ack_o),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_check(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at the first failing check");
    endtask

    // Ack is driven at the second edge after req is sampled, seen one edge later
    ack_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(req_i) |-> ##3 $rose(ack_o))
        else fail_check("ack_o did not rise 2 cycles after req_i was sampled high");
    ack_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_o && req_i |=> ack_o)
        else fail_check("ack_o dropped while req_i was still high");
    ack_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_o && !req_i |=> !ack_o)
        else fail_check("ack_o did not fall one cycle after req_i went low");
    ack_no_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ack_o) |-> req_i)
        else fail_check("ack_o rose while req_i was low");
    result_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_o && req_i |=> $stable(wb_en_o) && $stable(wb_addr_o) && $stable(wb_data_o)
                           && $stable(jump_o) && $stable(jump_addr_o))
        else fail_check("result outputs changed while ack_o was held");
    effect_gate: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ack_o |-> !wb_en_o && !jump_o)
        else fail_check("wb_en_o or jump_o high without ack_o");

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic rand_operands(output xlen_t imm, output xlen_t pc, output xlen_t rs1,
                                 output xlen_t rs2, output reg_addr_t rd);
        logic [31:0] bits;
        take_bits(32, imm);
        take_bits(32, pc);
        pc[1:0] = 2'b00;   // Word aligned
        take_bits(32, rs1);
        take_bits(32, rs2);
        take_bits(5, bits);
        rd = bits[4:0];
    endtask

    task automatic make_info(input disp_grp_e grp, input logic [3:0] op, input logic op2imm,
                             output dec_info_t info);
        logic [31:0] bits;
        take_bits(1, bits);
        info = '0;
        info[`EXU_DECINFO_GRP]    = grp;
        info[`EXU_DECINFO_OP]     = op;
        info[`EXU_DECINFO_OP2IMM] = op2imm;
        info[`EXU_DECINFO_RSV]    = bits[0];   // Must be ignored
    endtask

    // Expected writeback and redirect, from the instruction semantics
    task automatic model_txn(input dec_info_t info, input xlen_t imm, input xlen_t pc,
                             input xlen_t rs1, input xlen_t rs2, input reg_addr_t rd,
                             output logic exp_wb, output res_data_t exp_data,
                             output logic exp_jump, output pc_t exp_addr);
        disp_grp_e grp;
        alu_op_e   aop;
        bjp_op_e   bop;
        logic      use_imm;
        logic      writes;
        xlen_t     a;
        xlen_t     b;
        grp      = disp_grp_e'(info[`EXU_DECINFO_GRP]);
        aop      = alu_op_e'(info[`EXU_DECINFO_OP]);
        bop      = bjp_op_e'(info[`EXU_DECINFO_OP]);
        use_imm  = info[`EXU_DECINFO_OP2IMM];
        writes   = 1'b0;
        exp_data = '0;
        exp_jump = 1'b0;
        exp_addr = '0;
        if (grp == GRP_ALU) begin
            a = (aop == LUI) ? '0 : (aop == AUIPC) ? pc : rs1;
            b = use_imm ? imm : rs2;
            writes = 1'b1;
            case (aop)
                ADD, LUI, AUIPC: exp_data = a + b;
                SUB:             exp_data = a - b;
                SLL:             exp_data = a << b[4:0];
                SLT:             exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                SLTU:            exp_data = (a < b) ? 32'd1 : 32'd0;
                XOR:             exp_data = a ^ b;
                SRL:             exp_data = a >> b[4:0];
                SRA:             exp_data = $signed(a) >>> b[4:0];
                OR:              exp_data = a | b;
                AND:             exp_data = a & b;
                default:         writes = 1'b0;
            endcase
        end else if (grp == GRP_BJP) begin
            a = use_imm ? rs1 : pc;   // JALR uses the register base
            exp_addr = (a + imm) & ~32'd1;
            case (bop)
                JAL: begin
                    exp_jump = 1'b1;
                    writes   = 1'b1;
                    exp_data = pc + 32'd4;   // Link value
                end
                BEQ:     exp_jump = (rs1 == rs2);
                BNE:     exp_jump = (rs1 != rs2);
                BLT:     exp_jump = ($signed(rs1) < $signed(rs2));
                BGE:     exp_jump = ($signed(rs1) >= $signed(rs2));
                BLTU:    exp_jump = (rs1 < rs2);
                BGEU:    exp_jump = (rs1 >= rs2);
                default: exp_jump = 1'b0;
            endcase
        end
        exp_wb = writes && (rd != '0);
    endtask

    task automatic check_results(input logic exp_wb, input res_data_t exp_data,
                                 input reg_addr_t rd, input logic exp_jump, input pc_t exp_addr);
        assert (wb_en_o == exp_wb)
            else fail_check($sformatf("wb_en_o is %0b, expected %0b", wb_en_o, exp_wb));
        if (exp_wb) begin
            assert (wb_addr_o == rd)
                else fail_check($sformatf("wb_addr_o is %0d, expected %0d", wb_addr_o, rd));
            assert (wb_data_o == exp_data)
                else fail_check($sformatf("wb_data_o is %h, expected %h", wb_data_o, exp_data));
        end
        assert (jump_o == exp_jump)
            else fail_check($sformatf("jump_o is %0b, expected %0b", jump_o, exp_jump));
        if (exp_jump) begin
            assert (jump_addr_o == exp_addr)
                else fail_check($sformatf("jump_addr_o is %h, expected %h", jump_addr_o, exp_addr));
        end
    endtask

    // One four-phase transaction, with a random extra hold of the request
    task automatic run_txn(input dec_info_t info, input xlen_t imm, input xlen_t pc,
                           input xlen_t rs1, input xlen_t rs2, input reg_addr_t rd);
        logic        exp_wb;
        res_data_t   exp_data;
        logic        exp_jump;
        pc_t         exp_addr;
        logic [31:0] hold;
        model_txn(info, imm, pc, rs1, rs2, rd, exp_wb, exp_data, exp_jump, exp_addr);
        take_bits(1, hold);
        @(posedge clk);
        req_i       <= 1'b1;
        dec_info_i  <= info;
        dec_imm_i   <= imm;
        dec_pc_i    <= pc;
        rs1_rdata_i <= rs1;
        rs2_rdata_i <= rs2;
        rd_addr_i   <= rd;
        @(posedge clk);
        while (!ack_o) @(posedge clk);
        check_results(exp_wb, exp_data, rd, exp_jump, exp_addr);
        repeat (hold) @(posedge clk);
        req_i <= 1'b0;
        @(posedge clk);
        while (ack_o) @(posedge clk);
    endtask

    task automatic alu_tests();
        xlen_t     imm;
        xlen_t     pc;
        xlen_t     rs1;
        xlen_t     rs2;
        reg_addr_t rd;
        dec_info_t info;
        for (int op = 0; op < 12; op++) begin
            for (int src = 0; src < 2; src++) begin
                for (int rep = 0; rep < ALU_REPS; rep++) begin
                    rand_operands(imm, pc, rs1, rs2, rd);
                    if (rd == '0) rd = 5'd1;
                    make_info(GRP_ALU, op[3:0], src[0], info);
                    run_txn(info, imm, pc, rs1, rs2, rd);
                end
            end
        end
    endtask

    task automatic branch_tests();
        xlen_t       imm;
        xlen_t       pc;
        xlen_t       rs1;
        xlen_t       rs2;
        reg_addr_t   rd;
        dec_info_t   info;
        logic [31:0] bits;
        for (int op = 1; op <= 6; op++) begin
            for (int rep = 0; rep < BR_REPS; rep++) begin
                rand_operands(imm, pc, rs1, rs2, rd);
                take_bits(12, bits);
                imm = {{19{bits[11]}}, bits[11:0], 1'b0};   // B-type offset
                if (rep % 3 == 0) begin
                    rs2 = rs1;
                end else if (rep % 3 == 1) begin
                    rs2 = {~rs1[31], rs1[30:0]};   // Signed and unsigned order differ
                end
                make_info(GRP_BJP, op[3:0], 1'b0, info);
                run_txn(info, imm, pc, rs1, rs2, rd);
            end
        end
    endtask

    task automatic jump_tests();
        xlen_t       imm;
        xlen_t       pc;
        xlen_t       rs1;
        xlen_t       rs2;
        reg_addr_t   rd;
        dec_info_t   info;
        logic [31:0] bits;
        for (int jr = 0; jr < 2; jr++) begin
            for (int rep = 0; rep < JMP_REPS; rep++) begin
                rand_operands(imm, pc, rs1, rs2, rd);
                take_bits(21, bits);
                if (jr == 1) begin
                    imm = {{20{bits[11]}}, bits[11:0]};   // JALR, odd sums possible
                end else begin
                    imm = {{11{bits[20]}}, bits[20:1], 1'b0};
                end
                if (rd == '0) rd = 5'd1;
                make_info(GRP_BJP, 4'd0, jr[0], info);
                run_txn(info, imm, pc, rs1, rs2, rd);
            end
        end
    endtask

    task automatic misc_tests();
        xlen_t       imm;
        xlen_t       pc;
        xlen_t       rs1;
        xlen_t       rs2;
        reg_addr_t   rd;
        dec_info_t   info;
        logic [31:0] bits;
        for (int rep = 0; rep < MISC_REPS; rep++) begin
            rand_operands(imm, pc, rs1, rs2, rd);
            take_bits(5, bits);
            make_info(GRP_SYS, bits[3:0], bits[4], info);   // Nop
            run_txn(info, imm, pc, rs1, rs2, rd);
            rand_operands(imm, pc, rs1, rs2, rd);
            take_bits(5, bits);
            make_info(GRP_RSV, bits[3:0], bits[4], info);
            run_txn(info, imm, pc, rs1, rs2, rd);
            rand_operands(imm, pc, rs1, rs2, rd);
            take_bits(5, bits);
            make_info(GRP_ALU, bits[3:0] % 4'd12, bits[4], info);
            run_txn(info, imm, pc, rs1, rs2, 5'd0);   // Write to x0 dropped
            rand_operands(imm, pc, rs1, rs2, rd);
            make_info(GRP_BJP, 4'd0, 1'b0, info);
            run_txn(info, imm, pc, rs1, rs2, 5'd0);   // Plain jump, no link
        end
    endtask

    initial begin
        rst_n_i     <= 1'b0;
        req_i       <= 1'b0;
        dec_info_i  <= '0;
        dec_imm_i   <= '0;
        dec_pc_i    <= '0;
        rs1_rdata_i <= '0;
        rs2_rdata_i <= '0;
        rd_addr_i   <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk);
        assert (!ack_o && !wb_en_o && !jump_o)
            else fail_check("ack_o, wb_en_o or jump_o not 0 after reset");
        alu_tests();
        branch_tests();
        jump_tests();
        misc_tests();
        @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(WD_NS);
        $display("Watchdog expired, the DUT did not complete all transactions in time");
        $display("Test failures found");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

// File: exu/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_dec_pkg::*; import exu_res_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    input  wire        req_i,
    input  dec_info_t  dec_info_i,
    input  xlen_t      dec_imm_i,
    input  xlen_t      dec_pc_i,
    input  xlen_t      rs1_rdata_i,
    input  xlen_t      rs2_rdata_i,
    input  reg_addr_t  rd_addr_i,
    output logic       ack_o,
    output logic       wb_en_o,
    output reg_addr_t  wb_addr_o,
    output res_data_t  wb_data_o,
    output logic       jump_o,
    output pc_t        jump_addr_o
);

    logic      issue;
    logic      alu_valid;
    res_data_t alu_data;
    logic      bjp_valid;
    logic      bjp_taken;
    pc_t       bjp_target;

    alu_req_if alu_req ();
    bjp_req_if bjp_req ();

    exu_dispatch dispatch_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue),
        .dec_info_i  (dec_info_i),
        .dec_imm_i   (dec_imm_i),
        .dec_pc_i    (dec_pc_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .alu_o       (alu_req.disp),
        .bjp_o       (bjp_req.disp)
    );

    exu_alu alu_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (alu_req.unit),
        .valid_o (alu_valid),
        .data_o  (alu_data)
    );

    exu_bjp bjp_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (bjp_req.unit),
        .valid_o  (bjp_valid),
        .taken_o  (bjp_taken),
        .target_o (bjp_target)
    );

    exu_commit commit_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .rd_addr_i    (rd_addr_i),
        .alu_valid_i  (alu_valid),
        .alu_data_i   (alu_data),
        .bjp_valid_i  (bjp_valid),
        .bjp_taken_i  (bjp_taken),
        .bjp_target_i (bjp_target),
        .issue_o      (issue),
        .ack_o        (ack_o),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

`default_nettype wire

// File: exu/exu_commit.sv
`timescale 1ns/1ps
`default_nettype none

module exu_commit import exu_dec_pkg::*; import exu_res_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    input  wire        req_i,
    input  reg_addr_t  rd_addr_i,
    input  wire        alu_valid_i,
    input  res_data_t  alu_data_i,
    input  wire        bjp_valid_i,
    input  wire        bjp_taken_i,
    input  pc_t        bjp_target_i,
    output logic       issue_o,
    output logic       ack_o,
    output logic       wb_en_o,
    output reg_addr_t  wb_addr_o,
    output res_data_t  wb_data_o,
    output logic       jump_o,
    output pc_t        jump_addr_o
);

    commit_state_e state_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= C_IDLE;
            issue_o     <= 1'b0;
            ack_o       <= 1'b0;
            wb_en_o     <= 1'b0;
            wb_addr_o   <= '0;
            wb_data_o   <= '0;
            jump_o      <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            issue_o <= (state_q == C_IDLE) && req_i;   // Single pulse per request
            case (state_q)
                C_IDLE: begin
                    if (req_i) begin
                        state_q <= C_EXEC;
                    end
                end
                C_EXEC: begin
                    // First EXEC cycle is the issue, results arrive on the second
                    if (!issue_o) begin
                        ack_o       <= 1'b1;
                        wb_en_o     <= alu_valid_i && (rd_addr_i != '0);  // x0 is never written
                        wb_addr_o   <= rd_addr_i;
                        wb_data_o   <= alu_data_i;
                        jump_o      <= bjp_valid_i && bjp_taken_i;
                        jump_addr_o <= bjp_target_i;
                        state_q     <= C_ACK;
                    end
                end
                C_ACK: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        wb_en_o <= 1'b0;
                        jump_o  <= 1'b0;
                        state_q <= C_IDLE;
                    end
                end
                default: state_q <= C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: exu/exu_bjp.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bjp import exu_dec_pkg::*; import exu_res_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    bjp_req_if.unit    req_i,
    output logic       valid_o,
    output logic       taken_o,
    output pc_t        target_o
);

    logic taken_d;
    pc_t  target_d;

    always_comb begin
        case (req_i.op)
            JAL:     taken_d = 1'b1;   // JAL and JALR
            BEQ:     taken_d = (req_i.cmp_a == req_i.cmp_b);
            BNE:     taken_d = (req_i.cmp_a != req_i.cmp_b);
            BLT:     taken_d = ($signed(req_i.cmp_a) < $signed(req_i.cmp_b));
            BGE:     taken_d = ($signed(req_i.cmp_a) >= $signed(req_i.cmp_b));
            BLTU:    taken_d = (req_i.cmp_a < req_i.cmp_b);
            BGEU:    taken_d = (req_i.cmp_a >= req_i.cmp_b);
            default: taken_d = 1'b0;
        endcase
    end

    // JALR needs bit 0 cleared, harmless for the others
    assign target_d = (req_i.base + req_i.offset) & ~pc_t'(1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= req_i.start;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.start) begin
            taken_o  <= taken_d;
            target_o <= target_d;
        end
    end

endmodule

`default_nettype wire

// File: exu/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_dec_pkg::*; import exu_res_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    alu_req_if.unit    req_i,
    output logic       valid_o,
    output res_data_t  data_o
);

    logic [4:0] shamt;
    res_data_t  result;

    assign shamt = req_i.op2[4:0];   // RV32 shift amount

    always_comb begin
        case (req_i.op)
            ADD, LUI, AUIPC: result = req_i.op1 + req_i.op2;   // Operands picked by dispatch
            SUB:             result = req_i.op1 - req_i.op2;
            SLL:             result = req_i.op1 << shamt;
            SLT:             result = res_data_t'($signed(req_i.op1) < $signed(req_i.op2));
            SLTU:            result = res_data_t'(req_i.op1 < req_i.op2);
            XOR:             result = req_i.op1 ^ req_i.op2;
            SRL:             result = req_i.op1 >> shamt;
            SRA:             result = res_data_t'($signed(req_i.op1) >>> shamt);
            OR:              result = req_i.op1 | req_i.op2;
            AND:             result = req_i.op1 & req_i.op2;
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= req_i.start;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.start) begin
            data_o <= result;
        end
    end

endmodule

`default_nettype wire

// File: exu/exu_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defines.svh"

module exu_dispatch import exu_dec_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    input  wire        issue_i,
    input  dec_info_t  dec_info_i,
    input  xlen_t      dec_imm_i,
    input  xlen_t      dec_pc_i,
    input  xlen_t      rs1_rdata_i,
    input  xlen_t      rs2_rdata_i,
    alu_req_if.disp    alu_o,
    bjp_req_if.disp    bjp_o
);

    disp_grp_e grp;
    alu_op_e   alu_op;
    bjp_op_e   bjp_op;
    logic      op2imm;
    logic      sel_alu;
    logic      sel_bjp;
    logic      bjp_jump;
    xlen_t     alu_op1_d;
    xlen_t     alu_op2_d;

    logic      alu_sel_q;
    logic      bjp_sel_q;
    xlen_t     alu_op1_q;
    xlen_t     alu_op2_q;
    alu_op_e   alu_op_q;
    xlen_t     cmp_a_q;
    xlen_t     cmp_b_q;
    xlen_t     base_q;
    xlen_t     offset_q;
    bjp_op_e   bjp_op_q;

    assign grp      = disp_grp_e'(dec_info_i[`EXU_DECINFO_GRP]);
    assign alu_op   = alu_op_e'(dec_info_i[`EXU_DECINFO_OP]);
    assign bjp_op   = bjp_op_e'(dec_info_i[`EXU_DECINFO_OP]);
    assign op2imm   = dec_info_i[`EXU_DECINFO_OP2IMM];
    assign sel_alu  = (grp == GRP_ALU);
    assign sel_bjp  = (grp == GRP_BJP);
    assign bjp_jump = sel_bjp && (bjp_op == JAL);   // JAL and JALR need the link value

    always_comb begin
        if (bjp_jump || (sel_alu && alu_op == AUIPC)) begin
            alu_op1_d = dec_pc_i;
        end else if (sel_alu && alu_op != LUI) begin
            alu_op1_d = rs1_rdata_i;
        end else begin
            alu_op1_d = '0;   // LUI or ALU unused
        end
    end

    assign alu_op2_d = bjp_jump ? xlen_t'(4) :
                       !sel_alu ? '0 :
                       op2imm   ? dec_imm_i : rs2_rdata_i;

    // Unit select flags
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_sel_q <= 1'b0;
            bjp_sel_q <= 1'b0;
        end else begin
            alu_sel_q <= sel_alu || bjp_jump;
            bjp_sel_q <= sel_bjp;
        end
    end

    // Operand stage, inputs are held stable for the whole request
    always_ff @(posedge clk) begin
        alu_op1_q <= alu_op1_d;
        alu_op2_q <= alu_op2_d;
        alu_op_q  <= sel_alu ? alu_op : ADD;  // Link is PC + 4
        cmp_a_q   <= sel_bjp ? rs1_rdata_i : '0;
        cmp_b_q   <= sel_bjp ? rs2_rdata_i : '0;
        base_q    <= !sel_bjp ? '0 : op2imm ? rs1_rdata_i : dec_pc_i;
        offset_q  <= sel_bjp ? dec_imm_i : '0;
        bjp_op_q  <= bjp_op;
    end

    assign alu_o.start  = issue_i && alu_sel_q;
    assign alu_o.op1    = alu_op1_q;
    assign alu_o.op2    = alu_op2_q;
    assign alu_o.op     = alu_op_q;

    assign bjp_o.start  = issue_i && bjp_sel_q;
    assign bjp_o.cmp_a  = cmp_a_q;
    assign bjp_o.cmp_b  = cmp_b_q;
    assign bjp_o.base   = base_q;
    assign bjp_o.offset = offset_q;
    assign bjp_o.op     = bjp_op_q;

endmodule

`default_nettype wire

// File: common/exu_req_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface alu_req_if import exu_dec_pkg::*; ();

    logic    start;  // One-cycle pulse
    xlen_t   op1;
    xlen_t   op2;
    alu_op_e op;

    modport disp (output start, output op1, output op2, output op);
    modport unit (input start, input op1, input op2, input op);

endinterface

interface bjp_req_if import exu_dec_pkg::*; ();

    logic    start;   // One-cycle pulse
    xlen_t   cmp_a;   // Branch compare operands
    xlen_t   cmp_b;
    xlen_t   base;    // PC, or rs1 for JALR
    xlen_t   offset;
    bjp_op_e op;

    modport disp (output start, output cmp_a, output cmp_b,
                  output base, output offset, output op);
    modport unit (input start, input cmp_a, input cmp_b,
                  input base, input offset, input op);

endinterface

`default_nettype wire

// File: common/exu_res_pkg.sv
`default_nettype none

`include "exu_defines.svh"

package exu_res_pkg;

    typedef logic [`EXU_XLEN-1:0] res_data_t;   // Writeback value
    typedef logic [`EXU_XLEN-1:0] pc_t;         // Redirect target

    // Handshake FSM of the commit block
    typedef enum logic [1:0] {
        C_IDLE = 2'd0,   // Waiting for req
        C_EXEC = 2'd1,   // Units busy
        C_ACK  = 2'd2    // Results held until req drops
    } commit_state_e;

endpackage

`default_nettype wire

// File: common/exu_dec_pkg.sv
`default_nettype none

`include "exu_defines.svh"

package exu_dec_pkg;

    typedef logic [`EXU_DECINFO_WIDTH-1:0] dec_info_t;
    typedef logic [`EXU_XLEN-1:0]          xlen_t;     // Operands and immediates
    typedef logic [`EXU_REG_AW-1:0]        reg_addr_t;

    typedef enum logic [`EXU_DECINFO_GRP_W-1:0] {
        GRP_SYS = 2'd0,   // Nop only here
        GRP_ALU = 2'd1,
        GRP_BJP = 2'd2,
        GRP_RSV = 2'd3
    } disp_grp_e;

    typedef enum logic [`EXU_DECINFO_OP_W-1:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        LUI   = 4'd10,
        AUIPC = 4'd11
    } alu_op_e;

    // JALR is JAL with the OP2IMM flag set
    typedef enum logic [`EXU_DECINFO_OP_W-1:0] {
        JAL  = 4'd0,
        BEQ  = 4'd1,
        BNE  = 4'd2,
        BLT  = 4'd3,
        BGE  = 4'd4,
        BLTU = 4'd5,
        BGEU = 4'd6
    } bjp_op_e;

endpackage

`default_nettype wire

// File: common/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Datapath widths
`define EXU_XLEN            32
`define EXU_REG_AW          5

// Decode info bus from the decoder
`define EXU_DECINFO_WIDTH   8

// Field widths, used to size the group and op encodings
`define EXU_DECINFO_GRP_W   2
`define EXU_DECINFO_OP_W    4

// Field positions inside the decode info bus
`define EXU_DECINFO_GRP     1:0     // Instruction group
`define EXU_DECINFO_OP      5:2     // Operation within the group

// ALU: immediate as op2. BJP: register base (JALR)
`define EXU_DECINFO_OP2IMM  6

`define EXU_DECINFO_RSV     7       // Reserved, ignored by the EXU

`endif
